// ==== csr_settings.svh ====
`ifndef CSR_SETTINGS_SVH
`define CSR_SETTINGS_SVH

`define CSR_XLEN                64
`define CSR_ADDR_W              12
`define CSR_INSTR_W             32

// machine information
`define CSR_ADDR_MVENDORID      12'hf11
`define CSR_ADDR_MARCHID        12'hf12
`define CSR_ADDR_MIMPID         12'hf13
`define CSR_ADDR_MHARTID        12'hf14

// trap setup and handling
`define CSR_ADDR_MSTATUS        12'h300
`define CSR_ADDR_MISA           12'h301
`define CSR_ADDR_MIE            12'h304
`define CSR_ADDR_MTVEC          12'h305
`define CSR_ADDR_MSCRATCH       12'h340
`define CSR_ADDR_MEPC           12'h341
`define CSR_ADDR_MCAUSE         12'h342
`define CSR_ADDR_MTVAL          12'h343
`define CSR_ADDR_MIP            12'h344
`define CSR_ADDR_MTINST         12'h34a

// counters and timer compare
`define CSR_ADDR_CYCLE          12'hc00
`define CSR_ADDR_TIME           12'hc01
`define CSR_ADDR_MTIMECMP       12'hbbf

// exception codes
`define CSR_CAUSE_MISALIGNED    63'd0
`define CSR_CAUSE_ILLEGAL       63'd2
`define CSR_CAUSE_EBREAK        63'd3
`define CSR_CAUSE_LW_FAULT      63'd5
`define CSR_CAUSE_SW_FAULT      63'd7
`define CSR_CAUSE_ECALL         63'd11

// interrupt codes without the mcause bit 63
`define CSR_CAUSE_M_TIMER       63'd7
`define CSR_CAUSE_M_EXTERNAL    63'd11

`define CSR_M_MODE              2'b11

// mxl 2 with extensions a c i m s
`define CSR_MISA_VAL            64'h8000_0000_0004_1105

`endif

// ==== csr_pkg.sv ====
`include "csr_settings.svh"

package csr_pkg;

    typedef enum logic [1:0] {
        csr_op_none  = 2'd0,
        csr_op_rw    = 2'd1,
        csr_op_set   = 2'd2,
        csr_op_clear = 2'd3
    } csr_op_e;

    typedef struct packed {
        logic                   wen;
        csr_op_e                op;
        logic [`CSR_ADDR_W-1:0] addr;
        logic [`CSR_XLEN-1:0]   src;
    } csr_req_t;

    // one strobe per synchronous source
    typedef struct packed {
        logic illegal_id;
        logic illegal_exe;
        logic misaligned;
        logic ecall;
        logic ebreak;
        logic sw_fault;
        logic lw_fault;
        logic mret;
    } exc_evt_t;

    typedef struct packed {
        logic                    take;
        logic                    is_irq;
        logic [`CSR_XLEN-2:0]    code;
        logic [`CSR_XLEN-1:0]    epc;
        logic [`CSR_XLEN-1:0]    tval;
        logic [`CSR_INSTR_W-1:0] tinst;
    } trap_commit_t;

    typedef struct packed {
        logic                  mie;      // mstatus.MIE
        logic                  meie;
        logic                  mtie;
        logic [`CSR_XLEN-1:0]  mtvec;
        logic [`CSR_XLEN-1:0]  mcause;
        logic [`CSR_XLEN-1:0]  mepc;
    } csr_view_t;

    typedef struct packed {
        logic meip;
        logic mtip;
    } irq_pend_t;

endpackage

// ==== csr_timer_irq.sv ====
`timescale 1ns/10ps
`include "csr_settings.svh"

module csr_timer_irq import csr_pkg::*; (
    input  logic                 i_csr_unit_clk,
    input  logic                 i_csr_unit_rst_n,
    input  logic                 i_mexternal,
    input  logic [`CSR_XLEN-1:0] i_mtimecmp,
    output logic [`CSR_XLEN-1:0] o_counter,
    output irq_pend_t            o_pend
);

    logic [`CSR_XLEN-1:0] counter;
    irq_pend_t            pend;

    // free running counter shared by cycle and time
    always_ff @(posedge i_csr_unit_clk or negedge i_csr_unit_rst_n)
    begin
        if (!i_csr_unit_rst_n)
            counter <= '0;
        else
            counter <= counter + 1'b1;
    end

    // interrupts are sensed from flops only
    always_ff @(posedge i_csr_unit_clk or negedge i_csr_unit_rst_n)
    begin
        if (!i_csr_unit_rst_n)
        begin
            pend <= '0;
        end
        else
        begin
            pend.meip <= i_mexternal;
            pend.mtip <= (counter >= i_mtimecmp);
        end
    end

    assign o_counter = counter;
    assign o_pend    = pend;

endmodule

// ==== csr_regfile.sv ====
`timescale 1ns/10ps
`include "csr_settings.svh"

module csr_regfile import csr_pkg::*; (
    input  logic                 i_csr_unit_clk,
    input  logic                 i_csr_unit_rst_n,
    input  csr_req_t             i_req,
    input  trap_commit_t         i_commit,
    input  logic                 i_setting_up,
    input  logic                 i_mret,
    input  logic [`CSR_XLEN-1:0] i_counter,
    input  irq_pend_t            i_pend,
    output logic [`CSR_XLEN-1:0] o_rdata,
    output logic [`CSR_XLEN-1:0] o_mtimecmp,
    output csr_view_t            o_view
);

    // meie, mtie and the custom upper half
    localparam logic [`CSR_XLEN-1:0] mie_wmask = 64'hffff_ffff_ffff_0880;

    logic                 mstatus_mie;
    logic                 mstatus_mpie;
    logic [1:0]           mstatus_mpp;
    logic [`CSR_XLEN-1:0] mie_q;
    logic [`CSR_XLEN-1:0] mtvec;
    logic [`CSR_XLEN-1:0] mscratch;
    logic [`CSR_XLEN-1:0] mepc;
    logic [`CSR_XLEN-1:0] mcause;
    logic [`CSR_XLEN-1:0] mtval;
    logic [`CSR_XLEN-1:0] mtinst;
    logic [`CSR_XLEN-1:0] mtimecmp;

    logic [`CSR_XLEN-1:0] mstatus_val;
    logic [`CSR_XLEN-1:0] mip_val;
    logic [`CSR_XLEN-1:0] rdata;
    logic [`CSR_XLEN-1:0] op_result;

    always_comb
    begin
        mstatus_val        = '0;
        mstatus_val[3]     = mstatus_mie;
        mstatus_val[7]     = mstatus_mpie;
        mstatus_val[12:11] = mstatus_mpp;
        mip_val            = '0;
        mip_val[11]        = i_pend.meip;
        mip_val[7]         = i_pend.mtip;
    end

    always_comb
    begin
        case (i_req.addr)
            `CSR_ADDR_MVENDORID,
            `CSR_ADDR_MARCHID,
            `CSR_ADDR_MIMPID,
            `CSR_ADDR_MHARTID:  rdata = '0;
            `CSR_ADDR_MISA:     rdata = `CSR_MISA_VAL;
            `CSR_ADDR_MSTATUS:  rdata = mstatus_val;
            `CSR_ADDR_MIE:      rdata = mie_q;
            `CSR_ADDR_MIP:      rdata = mip_val;
            `CSR_ADDR_MTVEC:    rdata = mtvec;
            `CSR_ADDR_MSCRATCH: rdata = mscratch;
            `CSR_ADDR_MEPC:     rdata = mepc;
            `CSR_ADDR_MCAUSE:   rdata = mcause;
            `CSR_ADDR_MTVAL:    rdata = mtval;
            `CSR_ADDR_MTINST:   rdata = mtinst;
            `CSR_ADDR_CYCLE,
            `CSR_ADDR_TIME:     rdata = i_counter;
            `CSR_ADDR_MTIMECMP: rdata = mtimecmp;
            default:            rdata = '0;
        endcase
    end

    always_comb
    begin
        case (i_req.op)
            csr_op_rw:    op_result = i_req.src;
            csr_op_set:   op_result = rdata | i_req.src;
            csr_op_clear: op_result = rdata & ~i_req.src;
            default:      op_result = rdata;    // no change
        endcase
    end

    always_ff @(posedge i_csr_unit_clk or negedge i_csr_unit_rst_n)
    begin
        if (!i_csr_unit_rst_n)
        begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mstatus_mpp  <= `CSR_M_MODE;
            mie_q        <= '0;
            mtvec        <= '0;
            mscratch     <= '0;
            mepc         <= '0;
            mcause       <= '0;
            mtval        <= '0;
            mtinst       <= '0;
            mtimecmp     <= '0;
        end
        else
        begin
            if (i_req.wen)
            begin
                if (i_mret)
                begin
                    mstatus_mie  <= mstatus_mpie;
                    mstatus_mpie <= 1'b1;
                    mstatus_mpp  <= 2'b00;
                end
                else
                begin
                    case (i_req.addr)
                        `CSR_ADDR_MSTATUS:
                        begin
                            mstatus_mie  <= op_result[3];
                            mstatus_mpie <= op_result[7];
                            mstatus_mpp  <= op_result[12:11];
                        end
                        `CSR_ADDR_MIE:      mie_q    <= op_result & mie_wmask;
                        `CSR_ADDR_MTVEC:    mtvec    <= op_result;
                        `CSR_ADDR_MSCRATCH: mscratch <= op_result;
                        `CSR_ADDR_MEPC:     mepc     <= op_result;
                        `CSR_ADDR_MCAUSE:   mcause   <= op_result;
                        `CSR_ADDR_MTVAL:    mtval    <= op_result;
                        `CSR_ADDR_MTINST:   mtinst   <= op_result;
                        `CSR_ADDR_MTIMECMP: mtimecmp <= op_result;
                        default: ;
                    endcase
                end
            end
            else if (i_setting_up)
            begin
                // interrupts off inside the handler
                mstatus_mpie <= mstatus_mie;
                mstatus_mie  <= 1'b0;
            end

            // trap commit wins over a software write in the same cycle
            if (i_commit.take)
            begin
                mepc        <= i_commit.epc;
                mcause      <= {i_commit.is_irq, i_commit.code};
                mtval       <= i_commit.tval;
                mtinst      <= {{(`CSR_XLEN-`CSR_INSTR_W){1'b0}}, i_commit.tinst};
                mstatus_mpp <= `CSR_M_MODE;
            end
        end
    end

    assign o_rdata       = rdata;
    assign o_mtimecmp    = mtimecmp;
    assign o_view.mie    = mstatus_mie;
    assign o_view.meie   = mie_q[11];
    assign o_view.mtie   = mie_q[7];
    assign o_view.mtvec  = mtvec;
    assign o_view.mcause = mcause;
    assign o_view.mepc   = mepc;

endmodule

// ==== csr_trap_ctrl.sv ====
`timescale 1ns/10ps
`include "csr_settings.svh"

module csr_trap_ctrl import csr_pkg::*; (
    input  logic                    i_csr_unit_clk,
    input  logic                    i_csr_unit_rst_n,
    input  exc_evt_t                i_exc,
    input  logic [`CSR_XLEN-1:0]    i_pc,
    input  logic [`CSR_INSTR_W-1:0] i_instr,
    input  logic [`CSR_XLEN-1:0]    i_fault_addr,
    input  logic                    i_mem_wen,
    input  csr_view_t               i_view,
    input  irq_pend_t               i_pend,
    output trap_commit_t            o_commit,
    output logic                    o_setting_up,
    output logic                    o_ack,
    output logic                    o_pc_redirect,
    output logic                    o_addr_ctrl,
    output logic [`CSR_XLEN-1:0]    o_irq_handler,
    output logic [`CSR_XLEN-1:0]    o_rtrn_addr,
    output logic                    o_if_flush,
    output logic                    o_id_flush,
    output logic                    o_exe_flush,
    output logic                    o_mem_flush
);

    typedef enum logic {st_idle, st_setting_up} trap_state_e;

    trap_state_e          state;
    trap_commit_t         commit;
    logic                 irq_ext;
    logic                 irq_tmr;
    logic                 illegal;
    logic                 pending_exc;
    logic                 setting_up;
    logic                 ack_q;
    logic [`CSR_XLEN-1:0] tvec_base;
    logic                 mem_flush;
    logic                 exe_flush;

    assign irq_ext     = i_view.mie & i_view.meie & i_pend.meip;
    assign irq_tmr     = i_view.mie & i_view.mtie & i_pend.mtip;
    assign illegal     = i_exc.illegal_id | i_exc.illegal_exe;
    assign pending_exc = illegal | i_exc.misaligned | i_exc.ecall | i_exc.ebreak;
    assign setting_up  = (state == st_setting_up);

    // priority select only sampled while idle
    always_comb
    begin
        commit        = '0;
        commit.epc    = i_pc;
        commit.take   = ~setting_up;
        if (irq_ext)
        begin
            commit.is_irq = 1'b1;
            commit.code   = `CSR_CAUSE_M_EXTERNAL;
        end
        else if (irq_tmr)
        begin
            commit.is_irq = 1'b1;
            commit.code   = `CSR_CAUSE_M_TIMER;
        end
        else if (illegal)
            commit.code = `CSR_CAUSE_ILLEGAL;
        else if (i_exc.misaligned)
            commit.code = `CSR_CAUSE_MISALIGNED;
        else if (i_exc.ecall)
            commit.code = `CSR_CAUSE_ECALL;
        else if (i_exc.ebreak)
            commit.code = `CSR_CAUSE_EBREAK;
        else if (i_exc.sw_fault)
        begin
            commit.code = `CSR_CAUSE_SW_FAULT;
            commit.tval = i_fault_addr;
        end
        else if (i_exc.lw_fault)
        begin
            commit.code = `CSR_CAUSE_LW_FAULT;
            commit.tval = i_fault_addr;
        end
        else
            commit.take = 1'b0;     // nothing pending

        if (!commit.is_irq)
            commit.tinst = i_instr;
    end

    always_ff @(posedge i_csr_unit_clk or negedge i_csr_unit_rst_n)
    begin
        if (!i_csr_unit_rst_n)
        begin
            state <= st_idle;
            ack_q <= 1'b0;
        end
        else
        begin
            case (state)
                st_idle:
                begin
                    if (commit.take)
                        state <= st_setting_up;
                    ack_q <= commit.take & irq_ext;
                end
                default:
                begin
                    state <= st_idle;
                    ack_q <= 1'b0;
                end
            endcase
        end
    end

    // handler reads the stored mcause so it is valid in setting-up
    assign tvec_base = {i_view.mtvec[`CSR_XLEN-1:1], 1'b0};

    always_comb
    begin
        if (!i_view.mtvec[0])
            o_irq_handler = i_view.mtvec;
        else if (i_view.mcause[`CSR_XLEN-1])
            o_irq_handler = tvec_base + {i_view.mcause[`CSR_XLEN-3:0], 2'b00};
        else
            o_irq_handler = tvec_base;
    end

    assign mem_flush = i_exc.lw_fault | i_exc.sw_fault | (i_view.mie & i_mem_wen) | i_exc.mret;
    assign exe_flush = mem_flush | i_exc.illegal_exe | i_exc.misaligned | i_view.mie;

    assign o_mem_flush = mem_flush;
    assign o_exe_flush = exe_flush;
    assign o_id_flush  = exe_flush | pending_exc | i_view.mie;
    assign o_if_flush  = pending_exc | setting_up | i_view.mie | i_exc.mret;

    assign o_commit      = commit;
    assign o_setting_up  = setting_up;
    assign o_ack         = ack_q;
    assign o_pc_redirect = setting_up | i_exc.mret;
    assign o_addr_ctrl   = i_exc.mret;
    assign o_rtrn_addr   = i_view.mepc;

endmodule

// ==== core_csr_unit.sv ====
`timescale 1ns/10ps
`include "csr_settings.svh"

module core_csr_unit import csr_pkg::*; (
    input  logic                    i_csr_unit_clk,
    input  logic                    i_csr_unit_rst_n,
    input  logic [`CSR_XLEN-1:0]    i_csr_unit_pc,
    input  logic                    i_csr_unit_mem_wen,
    input  logic [`CSR_XLEN-1:0]    i_csr_unit_fault_addr,
    input  logic [`CSR_INSTR_W-1:0] i_csr_unit_instr,
    input  logic                    i_csr_unit_mexternal,
    input  logic                    i_csr_unit_csr_wen,
    input  csr_op_e                 i_csr_unit_op,
    input  logic [`CSR_XLEN-1:0]    i_csr_unit_src,
    input  logic [`CSR_ADDR_W-1:0]  i_csr_unit_csr_addr,
    input  logic                    i_csr_unit_mret,
    input  logic                    i_csr_unit_ecall,
    input  logic                    i_csr_unit_ebreak,
    input  logic                    i_csr_unit_illegal_instr_id,
    input  logic                    i_csr_unit_illegal_instr_exe,
    input  logic                    i_csr_unit_instr_addr_misaligned,
    input  logic                    i_csr_unit_lw_access_fault,
    input  logic                    i_csr_unit_sw_access_fault,
    output logic [`CSR_XLEN-1:0]    o_csr_unit_csr_rdata,
    output logic                    o_csr_unit_ack,
    output logic [`CSR_XLEN-1:0]    o_csr_unit_irq_handler,
    output logic [`CSR_XLEN-1:0]    o_csr_unit_rtrn_addr,
    output logic                    o_csr_unit_addr_ctrl,
    output logic                    o_csr_unit_pc_redirect,
    output logic                    o_csr_unit_if_flush,
    output logic                    o_csr_unit_id_flush,
    output logic                    o_csr_unit_exe_flush,
    output logic                    o_csr_unit_mem_flush
);

    csr_req_t             req;
    exc_evt_t             exc;
    trap_commit_t         commit;
    csr_view_t            view;
    irq_pend_t            pend;
    logic [`CSR_XLEN-1:0] counter;
    logic [`CSR_XLEN-1:0] mtimecmp;
    logic                 setting_up;

    assign req = '{wen: i_csr_unit_csr_wen, op: i_csr_unit_op,
                   addr: i_csr_unit_csr_addr, src: i_csr_unit_src};

    assign exc = '{illegal_id:  i_csr_unit_illegal_instr_id,
                   illegal_exe: i_csr_unit_illegal_instr_exe,
                   misaligned:  i_csr_unit_instr_addr_misaligned,
                   ecall:       i_csr_unit_ecall,
                   ebreak:      i_csr_unit_ebreak,
                   sw_fault:    i_csr_unit_sw_access_fault,
                   lw_fault:    i_csr_unit_lw_access_fault,
                   mret:        i_csr_unit_mret};

    csr_timer_irq u_csr_timer_irq (
        .i_csr_unit_clk   (i_csr_unit_clk),
        .i_csr_unit_rst_n (i_csr_unit_rst_n),
        .i_mexternal      (i_csr_unit_mexternal),
        .i_mtimecmp       (mtimecmp),
        .o_counter        (counter),
        .o_pend           (pend)
    );

    csr_regfile u_csr_regfile (
        .i_csr_unit_clk   (i_csr_unit_clk),
        .i_csr_unit_rst_n (i_csr_unit_rst_n),
        .i_req            (req),
        .i_commit         (commit),
        .i_setting_up     (setting_up),
        .i_mret           (exc.mret),
        .i_counter        (counter),
        .i_pend           (pend),
        .o_rdata          (o_csr_unit_csr_rdata),
        .o_mtimecmp       (mtimecmp),
        .o_view           (view)
    );

    csr_trap_ctrl u_csr_trap_ctrl (
        .i_csr_unit_clk   (i_csr_unit_clk),
        .i_csr_unit_rst_n (i_csr_unit_rst_n),
        .i_exc            (exc),
        .i_pc             (i_csr_unit_pc),
        .i_instr          (i_csr_unit_instr),
        .i_fault_addr     (i_csr_unit_fault_addr),
        .i_mem_wen        (i_csr_unit_mem_wen),
        .i_view           (view),
        .i_pend           (pend),
        .o_commit         (commit),
        .o_setting_up     (setting_up),
        .o_ack            (o_csr_unit_ack),
        .o_pc_redirect    (o_csr_unit_pc_redirect),
        .o_addr_ctrl      (o_csr_unit_addr_ctrl),
        .o_irq_handler    (o_csr_unit_irq_handler),
        .o_rtrn_addr      (o_csr_unit_rtrn_addr),
        .o_if_flush       (o_csr_unit_if_flush),
        .o_id_flush       (o_csr_unit_id_flush),
        .o_exe_flush      (o_csr_unit_exe_flush),
        .o_mem_flush      (o_csr_unit_mem_flush)
    );

endmodule

// ==== tb_core_csr_unit_asserts.sv ====
`timescale 1ns/10ps

module tb_core_csr_unit_asserts (
    input logic i_csr_unit_clk,
    input logic i_csr_unit_rst_n,
    input logic i_ack,
    input logic i_pc_redirect,
    input logic i_addr_ctrl,
    input logic i_if_flush,
    input logic i_id_flush,
    input logic i_exe_flush,
    input logic i_mem_flush
);

    logic any_out;
    logic failed;

    initial
        failed = 1'b0;

    assign any_out = i_ack | i_pc_redirect | i_addr_ctrl | i_if_flush
                   | i_id_flush | i_exe_flush | i_mem_flush;

    ack_single_cycle: assert property (
        @(posedge i_csr_unit_clk) disable iff (!i_csr_unit_rst_n)
        i_ack |=> !i_ack)
    else
    begin
        $error("ack stayed high for more than one cycle");
        failed = 1'b1;
    end

    // ack only ever marks a setting-up cycle
    ack_with_redirect: assert property (
        @(posedge i_csr_unit_clk) disable iff (!i_csr_unit_rst_n)
        i_ack |-> i_pc_redirect)
    else
    begin
        $error("ack high without pc_redirect");
        failed = 1'b1;
    end

    mem_implies_exe: assert property (
        @(posedge i_csr_unit_clk) disable iff (!i_csr_unit_rst_n)
        i_mem_flush |-> i_exe_flush)
    else
    begin
        $error("mem flush without exe flush");
        failed = 1'b1;
    end

    exe_implies_id: assert property (
        @(posedge i_csr_unit_clk) disable iff (!i_csr_unit_rst_n)
        i_exe_flush |-> i_id_flush)
    else
    begin
        $error("exe flush without id flush");
        failed = 1'b1;
    end

    quiet_after_reset: assert property (
        @(posedge i_csr_unit_clk)
        $rose(i_csr_unit_rst_n) |-> !any_out)
    else
    begin
        $error("outputs not low when reset was released");
        failed = 1'b1;
    end

endmodule

// ==== tb_core_csr_unit.sv ====
`timescale 1ns/10ps
`include "csr_settings.svh"

module tb_core_csr_unit import csr_pkg::*; ();

    logic                    clk;
    logic                    rst_n;
    logic [`CSR_XLEN-1:0]    pc;
    logic [`CSR_XLEN-1:0]    fault_addr;
    logic [`CSR_XLEN-1:0]    src;
    logic [`CSR_INSTR_W-1:0] instr;
    logic [`CSR_ADDR_W-1:0]  csr_addr;
    csr_op_e                 op;
    logic                    mem_wen;
    logic                    mexternal;
    logic                    csr_wen;
    logic                    mret;
    logic                    ecall;
    logic                    ebreak;
    logic                    ill_id;
    logic                    ill_exe;
    logic                    misaligned;
    logic                    lw_fault;
    logic                    sw_fault;

    logic [`CSR_XLEN-1:0]    rdata;
    logic [`CSR_XLEN-1:0]    irq_handler;
    logic [`CSR_XLEN-1:0]    rtrn_addr;
    logic                    ack;
    logic                    addr_ctrl;
    logic                    pc_redirect;
    logic                    if_flush;
    logic                    id_flush;
    logic                    exe_flush;
    logic                    mem_flush;

    logic [63:0]             rng_state;

    core_csr_unit u_core_csr_unit (
        .i_csr_unit_clk                   (clk),
        .i_csr_unit_rst_n                 (rst_n),
        .i_csr_unit_pc                    (pc),
        .i_csr_unit_mem_wen               (mem_wen),
        .i_csr_unit_fault_addr            (fault_addr),
        .i_csr_unit_instr                 (instr),
        .i_csr_unit_mexternal             (mexternal),
        .i_csr_unit_csr_wen               (csr_wen),
        .i_csr_unit_op                    (op),
        .i_csr_unit_src                   (src),
        .i_csr_unit_csr_addr              (csr_addr),
        .i_csr_unit_mret                  (mret),
        .i_csr_unit_ecall                 (ecall),
        .i_csr_unit_ebreak                (ebreak),
        .i_csr_unit_illegal_instr_id      (ill_id),
        .i_csr_unit_illegal_instr_exe     (ill_exe),
        .i_csr_unit_instr_addr_misaligned (misaligned),
        .i_csr_unit_lw_access_fault       (lw_fault),
        .i_csr_unit_sw_access_fault       (sw_fault),
        .o_csr_unit_csr_rdata             (rdata),
        .o_csr_unit_ack                   (ack),
        .o_csr_unit_irq_handler           (irq_handler),
        .o_csr_unit_rtrn_addr             (rtrn_addr),
        .o_csr_unit_addr_ctrl             (addr_ctrl),
        .o_csr_unit_pc_redirect           (pc_redirect),
        .o_csr_unit_if_flush              (if_flush),
        .o_csr_unit_id_flush              (id_flush),
        .o_csr_unit_exe_flush             (exe_flush),
        .o_csr_unit_mem_flush             (mem_flush)
    );

    bind core_csr_unit tb_core_csr_unit_asserts u_core_csr_unit_asserts (
        .i_csr_unit_clk   (i_csr_unit_clk),
        .i_csr_unit_rst_n (i_csr_unit_rst_n),
        .i_ack            (o_csr_unit_ack),
        .i_pc_redirect    (o_csr_unit_pc_redirect),
        .i_addr_ctrl      (o_csr_unit_addr_ctrl),
        .i_if_flush       (o_csr_unit_if_flush),
        .i_id_flush       (o_csr_unit_id_flush),
        .i_exe_flush      (o_csr_unit_exe_flush),
        .i_mem_flush      (o_csr_unit_mem_flush)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [63:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 7);
        rng_state = rng_state ^ (rng_state << 17);
        return rng_state;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp)
        else
        begin
            abort_run($sformatf("Mismatch at %0t ns: %s is 0x%h, expected 0x%h",
                                $time, name, got, exp));
        end
    endtask

    // idle levels for everything but pc, addr and mexternal
    task automatic clear_strobes();
        csr_wen    = 1'b0;
        op         = csr_op_none;
        mret       = 1'b0;
        ecall      = 1'b0;
        ebreak     = 1'b0;
        ill_id     = 1'b0;
        ill_exe    = 1'b0;
        misaligned = 1'b0;
        lw_fault   = 1'b0;
        sw_fault   = 1'b0;
        mem_wen    = 1'b0;
    endtask

    task automatic write_csr(input csr_op_e wop, input logic [11:0] waddr,
                             input logic [63:0] wsrc);
        @(negedge clk);
        clear_strobes();
        csr_wen  = 1'b1;
        op       = wop;
        csr_addr = waddr;
        src      = wsrc;
    endtask

    task automatic expect_csr(input string name, input logic [11:0] raddr,
                              input logic [63:0] exp);
        @(negedge clk);
        clear_strobes();
        csr_addr = raddr;
        #1;
        check_value(name, rdata, exp);
    endtask

    // watches mcause while waiting for pc_redirect or ack
    task automatic wait_for_trap(input bit want_ack);
        int   cycles;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < 20)
        begin
            @(negedge clk);
            clear_strobes();
            csr_addr = `CSR_ADDR_MCAUSE;
            #1;
            seen = want_ack ? ack : pc_redirect;
            cycles++;
        end
        if (!seen)
            abort_run(want_ack ? "timeout: ack never pulsed after the interrupt"
                               : "timeout: pc_redirect never rose after the trap");
    endtask

    always @(negedge clk)
    begin
        if (u_core_csr_unit.u_core_csr_unit_asserts.failed)
            abort_run("a protocol assertion on the DUT outputs failed");
    end

    initial
    begin
        logic [63:0] model;
        logic [63:0] r;
        logic [63:0] cyc0;
        logic [63:0] vbase;
        logic [63:0] dbase;
        logic        mie_bit;
        logic        exp_mem;
        logic        exp_exe;
        logic        exp_id;
        logic        exp_if;
        csr_op_e     wop;
        int          i;
        int          k;

        rng_state  = 64'd63;
        rst_n      = 1'b0;
        pc         = '0;
        fault_addr = '0;
        src        = '0;
        instr      = '0;
        csr_addr   = '0;
        mexternal  = 1'b0;
        clear_strobes();
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // rw / set / clear against a software model
        for (k = 0; k < 2; k++)
        begin
            model = '0;
            for (i = 0; i < 8; i++)
            begin
                r   = next_random();
                wop = csr_op_e'(r[1:0] % 3 + 1);
                r   = next_random();
                write_csr(wop, k ? `CSR_ADDR_MTVEC : `CSR_ADDR_MSCRATCH, r);
                case (wop)
                    csr_op_rw:  model = r;
                    csr_op_set: model = model | r;
                    default:    model = model & ~r;
                endcase
                expect_csr(k ? "mtvec" : "mscratch",
                           k ? `CSR_ADDR_MTVEC : `CSR_ADDR_MSCRATCH, model);
            end
        end

        r = next_random();
        write_csr(csr_op_rw, `CSR_ADDR_MSTATUS, r);
        expect_csr("mstatus", `CSR_ADDR_MSTATUS, r & 64'h1888);   // mie, mpie, mpp
        write_csr(csr_op_rw, `CSR_ADDR_MSTATUS, 64'd0);
        expect_csr("mstatus", `CSR_ADDR_MSTATUS, 64'd0);

        // rv64 with extensions a c i m s
        expect_csr("misa", `CSR_ADDR_MISA,
                   {2'b10, 62'd0} | (64'd1 << 0) | (64'd1 << 2) | (64'd1 << 8)
                   | (64'd1 << 12) | (64'd1 << 18));

        // mtimecmp is zero so mtip is already up
        expect_csr("mip", `CSR_ADDR_MIP, 64'h80);
        write_csr(csr_op_rw, `CSR_ADDR_MIP, next_random());
        expect_csr("mip", `CSR_ADDR_MIP, 64'h80);
        write_csr(csr_op_rw, 12'h7c0, next_random());
        expect_csr("unknown csr", 12'h7c0, 64'd0);

        @(negedge clk);
        clear_strobes();
        csr_addr = `CSR_ADDR_CYCLE;
        #1;
        cyc0 = rdata;
        repeat (3) @(negedge clk);
        #1;
        assert (rdata > cyc0)
        else
            abort_run("cycle counter did not advance between two reads");

        // vectored timer interrupt
        vbase = 64'h0000_0000_8000_0100;
        write_csr(csr_op_rw, `CSR_ADDR_MTVEC, vbase | 64'd1);
        write_csr(csr_op_rw, `CSR_ADDR_MTIMECMP, 64'd8);
        write_csr(csr_op_rw, `CSR_ADDR_MIE, 64'h80);
        pc = 64'h0000_0000_8000_1234;
        write_csr(csr_op_rw, `CSR_ADDR_MSTATUS, 64'h8);
        wait_for_trap(1'b0);
        check_value("o_csr_unit_ack", ack, 1'b0);
        check_value("mcause", rdata, {1'b1, 63'd7});
        check_value("o_csr_unit_rtrn_addr", rtrn_addr, pc);
        check_value("o_csr_unit_irq_handler", irq_handler, vbase + 4 * 7);
        expect_csr("mstatus", `CSR_ADDR_MSTATUS, 64'h1880);

        // external interrupt with the timer masked off
        write_csr(csr_op_rw, `CSR_ADDR_MIE, 64'h800);
        mexternal = 1'b1;
        pc        = 64'h0000_0000_8000_2468;
        write_csr(csr_op_rw, `CSR_ADDR_MSTATUS, 64'h8);
        wait_for_trap(1'b1);
        check_value("o_csr_unit_pc_redirect", pc_redirect, 1'b1);
        check_value("mcause", rdata, {1'b1, 63'd11});
        check_value("o_csr_unit_rtrn_addr", rtrn_addr, pc);
        check_value("o_csr_unit_irq_handler", irq_handler, vbase + 4 * 11);
        @(negedge clk);
        mexternal = 1'b0;

        // illegal beats ecall in direct mode
        dbase = 64'h0000_0000_8000_0200;
        write_csr(csr_op_rw, `CSR_ADDR_MTVEC, dbase);
        write_csr(csr_op_rw, `CSR_ADDR_MTVAL, next_random());
        @(negedge clk);
        clear_strobes();
        r        = next_random();
        instr    = r[31:0];
        pc       = 64'h0000_0000_8000_3000;
        ill_id   = 1'b1;
        ecall    = 1'b1;
        csr_addr = `CSR_ADDR_MCAUSE;
        wait_for_trap(1'b0);
        check_value("mcause", rdata, 64'd2);
        check_value("o_csr_unit_irq_handler", irq_handler, dbase);
        check_value("o_csr_unit_rtrn_addr", rtrn_addr, pc);
        expect_csr("mtinst", `CSR_ADDR_MTINST, {32'd0, instr});
        expect_csr("mtval", `CSR_ADDR_MTVAL, 64'd0);

        @(negedge clk);
        clear_strobes();
        fault_addr = next_random();
        pc         = 64'h0000_0000_8000_3010;
        lw_fault   = 1'b1;
        wait_for_trap(1'b0);
        check_value("mcause", rdata, 64'd5);
        expect_csr("mtval", `CSR_ADDR_MTVAL, fault_addr);

        // mret with mpie set beforehand
        write_csr(csr_op_rw, `CSR_ADDR_MSTATUS, 64'h1880);
        @(negedge clk);
        clear_strobes();
        csr_addr = `CSR_ADDR_MSTATUS;
        csr_wen  = 1'b1;
        mret     = 1'b1;
        #1;
        check_value("mstatus", rdata, 64'h1880);
        check_value("o_csr_unit_rtrn_addr", rtrn_addr, pc);
        check_value("o_csr_unit_addr_ctrl", addr_ctrl, 1'b1);
        check_value("o_csr_unit_pc_redirect", pc_redirect, 1'b1);
        expect_csr("mstatus", `CSR_ADDR_MSTATUS, 64'h88);     // mie from mpie, mpp cleared

        // flush equations with sparse strobes
        for (i = 0; i < 40; i++)
        begin
            r       = next_random();
            mie_bit = r[20];
            write_csr(csr_op_rw, `CSR_ADDR_MSTATUS, {60'd0, mie_bit, 3'd0});
            @(negedge clk);
            clear_strobes();
            r = next_random() & next_random();
            {ill_id, ill_exe, misaligned, ecall, ebreak, sw_fault, lw_fault, mret} = r[7:0];
            mem_wen = r[40];
            #1;
            exp_mem = lw_fault | sw_fault | (mie_bit & mem_wen) | mret;
            exp_exe = exp_mem | ill_exe | misaligned | mie_bit;
            exp_id  = exp_exe | ill_id | ill_exe | misaligned | ecall | ebreak | mie_bit;
            exp_if  = ill_id | ill_exe | misaligned | ecall | ebreak | mie_bit | mret;
            check_value("o_csr_unit_mem_flush", mem_flush, exp_mem);
            check_value("o_csr_unit_exe_flush", exe_flush, exp_exe);
            check_value("o_csr_unit_id_flush", id_flush, exp_id);
            check_value("o_csr_unit_if_flush", if_flush, exp_if);
        end

        @(negedge clk);
        clear_strobes();
        repeat (3) @(negedge clk);
        if (u_core_csr_unit.u_core_csr_unit_asserts.failed)
            abort_run("a protocol assertion on the DUT outputs failed");
        else
        begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

// ==== tb.f ====
+incdir+.
csr_pkg.sv
csr_timer_irq.sv
csr_regfile.sv
csr_trap_ctrl.sv
core_csr_unit.sv
tb_core_csr_unit_asserts.sv
tb_core_csr_unit.sv

// ==== Bender.yml ====
package:
  name: core_csr_unit

sources:
  - include_dirs:
      - .
    files:
      - csr_pkg.sv
      - csr_timer_irq.sv
      - csr_regfile.sv
      - csr_trap_ctrl.sv
      - core_csr_unit.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_core_csr_unit_asserts.sv
      - tb_core_csr_unit.sv
